// ==== sim.f ====
src/macPkg.sv
src/opSelect.sv
src/fp8Multiply.sv
src/productRound.sv
src/fp16Add.sv
src/accumulatorBank.sv
src/macTile.sv
tests/macTile_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module macTile_tb -o macTile_sim
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

output=$(./obj_dir/macTile_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" <<< "$output"; then
    exit 0
fi
exit 1

// ==== tests/macTile_tb.sv ====
`timescale 1ns/10ps

module macTile_tb;

    // One table row per cycle, applied to the slot of that cycle's phase
    typedef struct packed {
        macPkg::cmdT  cmd;
        macPkg::fp8T  a;
        macPkg::fp8T  b;
        macPkg::fp16T loadValue;
        macPkg::fp16T expAcc;  // accOut seen in this cycle
        logic         check;
    } rowT;

    logic         clk;
    logic         rst_n;
    macPkg::cmdT  cmd;
    macPkg::fp8T  a;
    macPkg::fp8T  b;
    macPkg::fp16T loadValue;
    macPkg::slotT phase;
    macPkg::fp16T accOut;

    rowT          stimulus[$];
    macPkg::slotT expPhase;
    int           errors;
    int           checks;
    int           cycleCount;
    int           cycleLimit = 1000;

    macTile macTile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .a         (a),
        .b         (b),
        .loadValue (loadValue),
        .phase     (phase),
        .accOut    (accOut)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic addRow(input macPkg::cmdT c, input macPkg::fp8T opA, input macPkg::fp8T opB,
                          input macPkg::fp16T ld, input macPkg::fp16T expected, input logic chk);
        stimulus.push_back(rowT'{c, opA, opB, ld, expected, chk});
    endtask

    // Expected values worked out by hand, slot = row index mod 4
    task automatic buildTable();
        // Fresh after reset, every slot reads 0
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h0000, 1'b1);
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h0000, 1'b1);
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h0000, 1'b1);
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h0000, 1'b1);
        // Loads 1.0, 2.0, 3.0, -1.0
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h3C00, 16'h0000, 1'b1);
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h4000, 16'h0000, 1'b1);
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h4200, 16'h0000, 1'b1);
        addRow(macPkg::Load, 8'h00, 8'h00, 16'hBC00, 16'h0000, 1'b1);
        // Loaded values read back while four Macs go in flight
        addRow(macPkg::Mac, 8'h3E, 8'h40, 16'h0000, 16'h3C00, 1'b1);  // 1.5*2 + 1 = 4
        addRow(macPkg::Mac, 8'h3D, 8'h40, 16'h0000, 16'h4000, 1'b1);  // 1.25*2 + 2 = 4.5
        addRow(macPkg::Mac, 8'h3E, 8'h3E, 16'h0000, 16'h4200, 1'b1);  // 2.25 + 3 = 5.25
        addRow(macPkg::Mac, 8'h38, 8'h42, 16'h0000, 16'hBC00, 1'b1);  // 1.5 - 1 = 0.5
        // Second round chains on the first, slot 2 idles
        addRow(macPkg::Mac, 8'h3E, 8'h40, 16'h0000, 16'h4400, 1'b1);  // 3 + 4 = 7
        addRow(macPkg::Mac, 8'h3C, 8'h3C, 16'h0000, 16'h4480, 1'b1);  // 1 + 4.5 = 5.5
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h4540, 1'b1);
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h5000, 16'h3800, 1'b1);  // 32.0
        // Rounding setup 2048, 2050, 2047 and a carry out 32 + 32
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h6800, 16'h4700, 1'b1);
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h6801, 16'h4580, 1'b1);
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h67FF, 16'h4540, 1'b1);
        addRow(macPkg::Mac, 8'h44, 8'h48, 16'h0000, 16'h5000, 1'b1);   // 4*8 + 32 = 64
        addRow(macPkg::Mac, 8'h3C, 8'h3C, 16'h0000, 16'h6800, 1'b1);   // 2049 ties to 2048
        addRow(macPkg::Mac, 8'h3C, 8'h3C, 16'h0000, 16'h6801, 1'b1);   // 2051 ties to 2052
        addRow(macPkg::Mac, 8'h3C, 8'h38, 16'h0000, 16'h67FF, 1'b1);   // 2047.5 to 2048
        addRow(macPkg::Mac, 8'h7E, 8'h3C, 16'h0000, 16'h5400, 1'b1);   // NaN operand
        // Specials
        addRow(macPkg::Mac, 8'h7C, 8'h00, 16'h0000, 16'h6800, 1'b1);   // Inf * 0
        addRow(macPkg::Mac, 8'hFC, 8'h3C, 16'h0000, 16'h6802, 1'b1);   // -Inf + finite
        addRow(macPkg::Load, 8'h00, 8'h00, 16'h7B00, 16'h6800, 1'b1);  // 57344
        addRow(macPkg::Mac, 8'h3C, 8'h3C, 16'h0000, 16'h7FFF, 1'b1);   // NaN accumulator
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h7FFF, 1'b1);
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'hFC00, 1'b1);
        addRow(macPkg::Mac, 8'h7B, 8'h3C, 16'h0000, 16'h7B00, 1'b1);   // Overflow to Inf
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h7FFF, 1'b1);
        // Final readout
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h7FFF, 1'b1);
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'hFC00, 1'b1);
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h7C00, 1'b1);
        addRow(macPkg::Idle, 8'h00, 8'h00, 16'h0000, 16'h7FFF, 1'b1);
    endtask

    task automatic checkRow(input rowT r);
        checks++;
        assert (phase === expPhase) else begin
            errors++;
            $display("ERROR at %0t: phase expected %0d, got %0d", $time, expPhase, phase);
        end
        if (r.check) begin
            checks++;
            assert (accOut === r.expAcc) else begin
                errors++;
                $display("ERROR at %0t: accOut expected %h, got %h", $time, r.expAcc, accOut);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cmd = macPkg::Idle;
        a = '0;
        b = '0;
        loadValue = '0;
        errors = 0;
        checks = 0;
        cycleCount = 0;
        expPhase = '0;
        buildTable();
        cycleLimit = stimulus.size() + 20;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;  // Phase 0 in this cycle

        foreach (stimulus[i]) begin
            cmd = stimulus[i].cmd;
            a = stimulus[i].a;
            b = stimulus[i].b;
            loadValue = stimulus[i].loadValue;
            #2;
            checkRow(stimulus[i]);
            expPhase = expPhase + 2'd1;  // Wraps 3 to 0
            @(posedge clk);
            #1;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== src/macTile.sv ====
`timescale 1ns/10ps

module macTile (
    input  logic         clk,
    input  logic         rst_n,
    input  macPkg::cmdT  cmd,
    input  macPkg::fp8T  a,
    input  macPkg::fp8T  b,
    input  macPkg::fp16T loadValue,
    output macPkg::slotT phase,
    output macPkg::fp16T accOut
);
    macPkg::fp16T [macPkg::SlotCount-1:0] accValues;
    macPkg::issueT     issue;
    macPkg::writebackT loadReq;
    macPkg::rawProdT   prod;
    macPkg::prodStageT stage;
    macPkg::writebackT wb;

    opSelect opSelect_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .a         (a),
        .b         (b),
        .loadValue (loadValue),
        .accValues (accValues),
        .phase     (phase),
        .accCur    (accOut),
        .issue     (issue),
        .loadReq   (loadReq)
    );

    // Stage 1
    fp8Multiply fp8Multiply_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .a          (issue.a),
        .b          (issue.b),
        .accValue   (issue.acc),
        .slot       (issue.slot),
        .issueValid (issue.valid),
        .prod       (prod)
    );

    // Stage 2
    productRound productRound_i (
        .clk   (clk),
        .rst_n (rst_n),
        .prod  (prod),
        .stage (stage)
    );

    // Stage 3
    fp16Add fp16Add_i (
        .clk   (clk),
        .rst_n (rst_n),
        .stage (stage),
        .wb    (wb)
    );

    accumulatorBank accumulatorBank_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .loadReq   (loadReq),
        .wb        (wb),
        .accValues (accValues)
    );

endmodule

// ==== src/accumulatorBank.sv ====
`timescale 1ns/10ps

module accumulatorBank (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  macPkg::writebackT                     loadReq,
    input  macPkg::writebackT                     wb,
    output macPkg::fp16T [macPkg::SlotCount-1:0] accValues
);
    // Load and writeback never hit the same slot in one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accValues <= '0;
        end else begin
            for (int i = 0; i < macPkg::SlotCount; i++) begin
                if (loadReq.valid && loadReq.slot == macPkg::slotT'(i)) begin
                    accValues[i] <= loadReq.value;
                end else if (wb.valid && wb.slot == macPkg::slotT'(i)) begin
                    accValues[i] <= wb.value;  // Result of the op issued 4 cycles back
                end
            end
        end
    end

endmodule

// ==== src/fp16Add.sv ====
`timescale 1ns/10ps

module fp16Add (
    input  logic              clk,
    input  logic              rst_n,
    input  macPkg::prodStageT stage,
    output macPkg::writebackT wb
);
    macPkg::fp16T p;
    macPkg::fp16T c;
    logic         pNan, pInf;
    logic         cNan, cInf;
    logic         swap;
    macPkg::fp16T bigOp;
    macPkg::fp16T smallOp;
    logic [4:0]   bigExp;
    logic [4:0]   smallExp;
    logic [4:0]   expDiff;
    logic [13:0]  bigFrame;
    logic [13:0]  smallFrame;
    logic [13:0]  lostMask;
    logic [13:0]  aligned;
    logic [14:0]  sum;
    logic [3:0]   lz;
    logic [3:0]   lShift;
    logic [13:0]  norm;
    logic [5:0]   normExp;
    logic         roundUp;
    logic [11:0]  rounded;
    logic [5:0]   finalExp;
    logic [9:0]   finalMant;
    macPkg::fp16T sumHalf;

    assign p = stage.product;
    assign c = stage.acc;

    assign pNan = (p[14:10] == macPkg::HalfInfExp) && (p[9:0] != 10'd0);
    assign pInf = (p[14:10] == macPkg::HalfInfExp) && (p[9:0] == 10'd0);
    assign cNan = (c[14:10] == macPkg::HalfInfExp) && (c[9:0] != 10'd0);
    assign cInf = (c[14:10] == macPkg::HalfInfExp) && (c[9:0] == 10'd0);

    // Larger magnitude first and the product wins a tie
    assign swap    = c[14:0] > p[14:0];
    assign bigOp   = swap ? c : p;
    assign smallOp = swap ? p : c;

    assign bigExp     = (bigOp[14:10] == 5'd0) ? 5'd1 : bigOp[14:10];
    assign smallExp   = (smallOp[14:10] == 5'd0) ? 5'd1 : smallOp[14:10];
    assign bigFrame   = {bigOp[14:10] != 5'd0, bigOp[9:0], 3'b000};
    assign smallFrame = {smallOp[14:10] != 5'd0, smallOp[9:0], 3'b000};

    // Align with sticky so large gaps collapse into the sticky bit
    assign expDiff  = bigExp - smallExp;
    assign lostMask = (14'd1 << expDiff) - 14'd1;
    assign aligned  = (smallFrame >> expDiff) | {13'd0, |(smallFrame & lostMask)};

    assign sum = (bigOp[15] == smallOp[15]) ? {1'b0, bigFrame} + {1'b0, aligned}
                                            : {1'b0, bigFrame} - {1'b0, aligned};

    always_comb begin
        lz = 4'd14;  // All zero
        for (int i = 0; i < 14; i++) begin
            if (sum[i]) begin
                lz = 4'(13 - i);
            end
        end
    end

    // Stop the left shift at the minimum exponent
    assign lShift = (5'(lz) < bigExp - 5'd1) ? lz : 4'(bigExp - 5'd1);

    always_comb begin
        if (sum[14]) begin
            norm = {sum[14:2], sum[1] | sum[0]};  // Carry out
            normExp = 6'(bigExp) + 6'd1;
        end else begin
            norm = sum[13:0] << lShift;
            normExp = 6'(bigExp) - 6'(lShift);
        end
    end

    assign roundUp = norm[2] & (norm[3] | norm[1] | norm[0]);
    assign rounded = {1'b0, norm[13:3]} + 12'(roundUp);

    // Renormalize when rounding carries past the hidden bit
    assign finalExp  = rounded[11] ? normExp + 6'd1 : normExp;
    assign finalMant = rounded[9:0];  // Zero after such a carry

    always_comb begin
        if (pNan || cNan || (pInf && cInf && (p[15] != c[15]))) begin
            sumHalf = macPkg::HalfNan;
        end else if (pInf || cInf || finalExp >= macPkg::Fp16ExpMax) begin
            sumHalf = {bigOp[15], macPkg::HalfInfExp, 10'd0};
        end else if (sum == 15'd0) begin
            sumHalf = {bigOp[15], 15'd0};
        end else if (rounded[11] || rounded[10]) begin
            sumHalf = {bigOp[15], finalExp[4:0], finalMant};
        end else begin
            sumHalf = {bigOp[15], 5'd0, finalMant};  // Subnormal result
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= stage.valid;
            wb.slot <= stage.slot;
            wb.value <= sumHalf;
        end
    end

endmodule

// ==== src/productRound.sv ====
`timescale 1ns/10ps

module productRound (
    input  logic              clk,
    input  logic              rst_n,
    input  macPkg::rawProdT   prod,
    output macPkg::prodStageT stage
);
    logic [2:0]   lz;
    logic [7:0]   normMant;
    macPkg::sexpT normExp;
    logic [3:0]   rShift;
    logic [13:0]  frame;
    logic [13:0]  lostMask;
    logic [13:0]  shifted;
    logic         roundUp;
    logic [10:0]  rounded;
    macPkg::fp16T prodHalf;

    // Leading zeros of the raw product, highest set bit wins
    always_comb begin
        lz = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if (prod.mant[i]) begin
                lz = 3'(7 - i);
            end
        end
    end

    assign normMant = prod.mant << lz;
    assign normExp  = prod.exp + 7'sd1 - $signed({4'b0000, lz});

    // Right shift into the subnormal range
    assign rShift   = (normExp > 7'sd0) ? 4'd0 : 4'(7'sd1 - normExp);
    assign frame    = {normMant, 6'b000000};  // Hidden bit at 13, G R S at 2..0
    assign lostMask = (14'd1 << rShift) - 14'd1;
    assign shifted  = (frame >> rShift) | {13'd0, |(frame & lostMask)};

    // Nearest even
    assign roundUp = shifted[2] & (shifted[3] | shifted[1] | shifted[0]);
    assign rounded = shifted[13:3] + 11'(roundUp);

    always_comb begin
        if (prod.nan) begin
            prodHalf = macPkg::HalfNan;
        end else if (prod.inf || normExp >= macPkg::Fp16ExpMax) begin
            prodHalf = {prod.sign, macPkg::HalfInfExp, 10'd0};
        end else if (prod.zero || normExp < -10) begin
            prodHalf = '0;
        end else if (rounded[10]) begin
            // Rounding out of the subnormal range lands on exponent 1
            prodHalf = {prod.sign, (normExp > 7'sd0) ? 5'(normExp) : 5'd1, rounded[9:0]};
        end else begin
            prodHalf = {prod.sign, 5'd0, rounded[9:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= prod.valid;
            stage.slot <= prod.slot;
            stage.product <= prodHalf;
            stage.acc <= prod.acc;
        end
    end

endmodule

// ==== src/fp8Multiply.sv ====
`timescale 1ns/10ps

module fp8Multiply (
    input  logic            clk,
    input  logic            rst_n,
    input  macPkg::fp8T     a,
    input  macPkg::fp8T     b,
    input  macPkg::fp16T    accValue,
    input  macPkg::slotT    slot,
    input  logic            issueValid,
    output macPkg::rawProdT prod
);
    logic [4:0] aExp;
    logic [4:0] bExp;
    logic [4:0] aEff;
    logic [4:0] bEff;
    logic       aNan, aInf, aZero, aSub;
    logic       bNan, bInf, bZero, bSub;
    logic [3:0] aSig;
    logic [3:0] bSig;
    logic       nanNext, infNext, zeroNext;

    assign aExp = a[6:2];
    assign bExp = b[6:2];

    // Operand classes
    assign aNan  = (aExp == 5'h1f) && (a[1:0] != 2'b00);
    assign aInf  = (aExp == 5'h1f) && (a[1:0] == 2'b00);
    assign aZero = (aExp == 5'h00) && (a[1:0] == 2'b00);
    assign aSub  = (aExp == 5'h00) && (a[1:0] != 2'b00);
    assign bNan  = (bExp == 5'h1f) && (b[1:0] != 2'b00);
    assign bInf  = (bExp == 5'h1f) && (b[1:0] == 2'b00);
    assign bZero = (bExp == 5'h00) && (b[1:0] == 2'b00);
    assign bSub  = (bExp == 5'h00) && (b[1:0] != 2'b00);

    assign nanNext  = aNan | bNan | (aInf & bZero) | (aZero & bInf);
    assign infNext  = ~nanNext & (aInf | bInf);
    assign zeroNext = ~nanNext & ~infNext & (aZero | bZero | (aSub & bSub));

    // Subnormals act as exponent 1 with no hidden bit
    assign aEff = aSub ? 5'd1 : aExp;
    assign bEff = bSub ? 5'd1 : bExp;
    assign aSig = {aExp != 5'd0, a[1:0], 1'b0};
    assign bSig = {bExp != 5'd0, b[1:0], 1'b0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= issueValid;
            prod.slot <= slot;
            prod.nan <= nanNext;
            prod.inf <= infNext;
            prod.zero <= zeroNext;
            prod.sign <= a[7] ^ b[7];
            prod.exp <= 7'(aEff) + 7'(bEff) - 7'(macPkg::Fp8Bias);  // FP16 biased
            prod.mant <= aSig * bSig;
            prod.acc <= accValue;
        end
    end

endmodule

// ==== src/opSelect.sv ====
`timescale 1ns/10ps

module opSelect (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  macPkg::cmdT                           cmd,
    input  macPkg::fp8T                           a,
    input  macPkg::fp8T                           b,
    input  macPkg::fp16T                          loadValue,
    input  macPkg::fp16T [macPkg::SlotCount-1:0] accValues,
    output macPkg::slotT                          phase,
    output macPkg::fp16T                          accCur,
    output macPkg::issueT                         issue,
    output macPkg::writebackT                     loadReq
);
    // Free running slot rotation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (phase == macPkg::slotT'(macPkg::SlotCount - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 2'd1;
        end
    end

    assign accCur = accValues[phase];  // Also the visible accOut

    always_comb begin
        issue.valid = (cmd == macPkg::Mac);
        issue.slot = phase;
        issue.a = a;
        issue.b = b;
        issue.acc = accCur;

        loadReq.valid = (cmd == macPkg::Load);
        loadReq.slot = phase;
        loadReq.value = loadValue;
    end

endmodule

// ==== src/macPkg.sv ====
package macPkg;

    // Number formats
    typedef logic [7:0]        fp8T;   // E5M2
    typedef logic [15:0]       fp16T;  // IEEE half
    typedef logic [1:0]        slotT;  // Accumulator index and phase
    typedef logic signed [6:0] sexpT;  // Biased exponent before range checks

    typedef enum logic [1:0] {
        Idle = 2'd0,
        Mac  = 2'd1,
        Load = 2'd2
    } cmdT;

    localparam int SlotCount = 4;   // One slot per pipeline stage
    localparam int Fp8Bias = 15;
    localparam int Fp16ExpMax = 31;
    localparam fp16T HalfNan = 16'h7FFF;
    localparam logic [4:0] HalfInfExp = 5'b11111;

    // Operands entering the multiplier
    typedef struct packed {
        logic valid;
        slotT slot;
        fp8T  a;
        fp8T  b;
        fp16T acc;
    } issueT;

    typedef struct packed {
        logic       valid;
        slotT       slot;
        logic       nan;
        logic       inf;
        logic       zero;
        logic       sign;
        sexpT       exp;
        logic [7:0] mant;  // 1.0 sits at bit 6
        fp16T       acc;
    } rawProdT;

    typedef struct packed {
        logic valid;
        slotT slot;
        fp16T product;
        fp16T acc;
    } prodStageT;

    // Also used for direct loads
    typedef struct packed {
        logic valid;
        slotT slot;
        fp16T value;
    } writebackT;

endpackage
